// File: bus_ctrl_pkg.sv
package bus_ctrl_pkg;

    localparam int DATA_WIDTH = 16;
    localparam int ADDR_WIDTH = 12;          // master address width
    localparam int M_COUNT = 2;              // internal masters, the external one sits on bit M_COUNT
    localparam int MID_WIDTH = 1;            // master index width
    localparam int SID_WIDTH = 2;            // slave id, 0 selects no slave
    localparam int SLAVE_DEPTHS [3] = '{4096, 4096, 2048};  // indexed by slave id minus one
    localparam int BANK_DEPTH = 16;          // bank words per master
    localparam int BANK_AW = 4;
    localparam int CONFIG_CLK_COUNT = 2;     // cycles spent in each config sub-state
    localparam int COM_START_DELAY = 3;      // extra wait before the second master starts
    localparam int FIRST_START_MASTER = 0;

    typedef enum logic [3:0] {
        slave_sel,
        rw_sel,
        ext_write_sel,
        ext_write_m0,
        ext_write_m01,     // master 0 words first, then master 1
        ext_write_m1,
        first_addr_m0,
        first_addr_m1,
        len_m0,
        len_m1,
        config_masters,
        com_ready,
        communicating,
        com_done
    } main_state_t;

    typedef enum logic [1:0] {
        cfg_start,
        cfg_middle,
        cfg_last,
        cfg_done           // idle between configuration runs
    } config_state_t;

endpackage

// File: bus_ctrl_tb.sv
`timescale 1ns/1ns

module bus_ctrl_tb;

    localparam int MAX_TESTS = 32;
    localparam int NUM_COLS = 20;
    localparam int COL_SID = 0;        // master 0, master 1 in the next column
    localparam int COL_RW = 2;
    localparam int COL_INEX = 3;
    localparam int COL_FIRST = 4;
    localparam int COL_LEN = 6;
    localparam int COL_LAST = 8;
    localparam int COL_NWORDS = 10;
    localparam int COL_WORDS = 12;     // four bank words per master
    localparam int CYCLES_PER_TEST = 400;

    logic clk;
    logic rstN;
    logic advance;
    logic next_addr;
    logic ext_toggle;
    logic [bus_ctrl_pkg::DATA_WIDTH-1:0] sw;
    logic [bus_ctrl_pkg::M_COUNT-1:0] m_done;
    logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::SID_WIDTH-1:0] m_slave_id;
    logic [bus_ctrl_pkg::M_COUNT-1:0] m_rd_wr;
    logic [bus_ctrl_pkg::M_COUNT-1:0] m_in_ex;
    logic [bus_ctrl_pkg::M_COUNT-1:0] m_burst;
    logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::ADDR_WIDTH-1:0] m_address;
    logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::DATA_WIDTH-1:0] m_data;
    logic [bus_ctrl_pkg::M_COUNT:0] m_start;
    logic [bus_ctrl_pkg::M_COUNT:0] m_eoc;
    logic [3:0] status_led;

    int tests [MAX_TESTS][NUM_COLS];
    int num_tests;
    int cur;                           // scenario being run

    bus_ctrl_top dut0 (.*);

    initial clk = 1'b0;
    always #50 clk = !clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic mismatch(input string what);
        stop_run($sformatf("[FAIL] %0t ns: %s", $time, what));
    endtask

    function automatic int field(input int col);
        return tests[cur][col];
    endfunction

    function automatic int word(input int m, input int i);
        return tests[cur][COL_WORDS + 4 * m + i];
    endfunction

    function automatic bit wants_words(input int m);
        return ((field(COL_INEX) >> m) & 1) != 0;
    endfunction

    task automatic idle_gap();
        repeat ($urandom_range(3, 1)) @(negedge clk);
    endtask

    // sw is captured on the same edge that sees the strobe
    task automatic press_advance(input int value);
        idle_gap();
        sw = value;
        advance = 1'b1;
        @(negedge clk);
        advance = 1'b0;
    endtask

    task automatic reset_dut();
        rstN = 1'b0;
        advance = 1'b0;
        next_addr = 1'b0;
        ext_toggle = 1'b0;
        sw = '0;
        m_done = '0;
        repeat (10) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        assert (m_start == '0 && m_eoc == '0 && m_burst == '0 && status_led == 4'b0001)
        else mismatch($sformatf("not idle after reset, leds %b", status_led));
    endtask

    // n words take n-1 next_addr strobes, the last one leaves with advance
    task automatic enter_words(input int m);
        int n;
        n = field(COL_NWORDS + m);
        for (int i = 0; i < n - 1; i++) begin
            sw = word(m, i);
            idle_gap();
            next_addr = 1'b1;
            @(negedge clk);
            next_addr = 1'b0;
        end
        press_advance(word(m, n - 1));
    endtask

    task automatic check_settings();
        logic [1:0] burst;
        for (int m = 0; m < 2; m++) begin
            burst[m] = wants_words(m) && field(COL_NWORDS + m) > 1;
        end
        assert (m_slave_id[0] == field(COL_SID) && m_slave_id[1] == field(COL_SID + 1)
                && m_rd_wr == field(COL_RW) && m_in_ex == field(COL_INEX) && m_burst == burst)
        else mismatch($sformatf("settings sid %h rw %b in_ex %b burst %b, burst expected %b",
                                m_slave_id, m_rd_wr, m_in_ex, m_burst, burst));
    endtask

    // expected order: m0 first, m0 last, m1 first, m1 last
    task automatic check_config();
        int k;
        int m;
        int cycles;
        int exp_addr;
        int exp_data;
        k = 0;
        cycles = 0;
        while (!status_led[1]) begin
            if (m_start[1:0] != '0) begin
                m = k / 2;
                assert (k < 4 && m_start[1:0] == (2'b01 << m))
                else mismatch($sformatf("config start %b at pulse %0d", m_start, k));
                exp_addr = (k % 2) ? field(COL_LAST + m) : field(COL_FIRST + m);
                exp_data = (k % 2) ? word(m, field(COL_NWORDS + m) - 1) : word(m, 0);
                assert (m_address[m] == exp_addr)
                else mismatch($sformatf("master %0d address %h, expected %h",
                                        m, m_address[m], exp_addr));
                if (wants_words(m)) begin
                    assert (m_data[m] == exp_data)
                    else mismatch($sformatf("master %0d data %h, expected %h",
                                            m, m_data[m], exp_data));
                end
                k++;
            end
            cycles++;
            if (cycles > 200) stop_run("timed out waiting for the configuration to finish");
            @(negedge clk);
        end
        assert (k == 4) else mismatch($sformatf("%0d config start pulses instead of 4", k));
    endtask

    task automatic check_launch();
        int first_m;
        int t_first;
        int t_other;
        first_m = bus_ctrl_pkg::FIRST_START_MASTER;
        t_first = -1;
        t_other = -1;
        press_advance(0);
        for (int t = 0; t < 20 && t_other < 0; t++) begin
            if (m_start[first_m]) t_first = t;
            if (m_start[1 - first_m]) t_other = t;
            @(negedge clk);
        end
        assert (t_first == 0 && t_other - t_first == bus_ctrl_pkg::COM_START_DELAY + 1)
        else mismatch($sformatf("start of first master at %0d, other at %0d", t_first, t_other));
        assert (status_led[3]) else mismatch("not communicating after launch");
    endtask

    task automatic check_done();
        logic [1:0] active;
        for (int m = 0; m < 2; m++) begin
            active[m] = field(COL_SID + m) != 0;
        end
        idle_gap();
        assert (!status_led[2]) else mismatch("com_done before any master finished");
        if (active == 2'b11) begin
            m_done = 2'b01;
            idle_gap();
            assert (!status_led[2]) else mismatch("com_done while master 1 still busy");
        end
        m_done = active;
        for (int t = 0; !status_led[2]; t++) begin
            if (t > 20) stop_run("timed out waiting for com_done after the masters finished");
            @(negedge clk);
        end
    endtask

    task automatic check_ext_session();
        logic [bus_ctrl_pkg::DATA_WIDTH-1:0] value;
        for (int i = 0; i < 4; i++) begin
            idle_gap();
            ext_toggle = 1'b1;
            @(negedge clk);
            ext_toggle = 1'b0;
            assert (m_start[2] == (i % 2 == 0) && m_eoc[2] == (i % 2 == 1))
            else mismatch($sformatf("toggle %0d gave start %b eoc %b", i, m_start[2], m_eoc[2]));
        end
        for (int i = 0; i < 3; i++) begin
            value = $urandom;
            sw = value;
            @(negedge clk);
            assert (m_address[0] == value[11:0] && m_address[1] == value[11:0])
            else mismatch($sformatf("address %h does not follow sw %h", m_address, value));
        end
    endtask

    task automatic run_scenario();
        reset_dut();
        press_advance(field(COL_SID + 1) * 4 + field(COL_SID));
        if (field(COL_SID) == 0 && field(COL_SID + 1) == 0) begin
            assert (status_led[2] && m_eoc[1:0] == 2'b11)
            else mismatch("empty slave selection did not jump to com_done");
        end else begin
            press_advance(field(COL_RW));
            press_advance(field(COL_INEX));
            if (wants_words(0)) enter_words(0);
            if (wants_words(1)) enter_words(1);
            press_advance(field(COL_FIRST));
            press_advance(field(COL_FIRST + 1));
            press_advance(field(COL_LEN));
            press_advance(field(COL_LEN + 1));  // cfg_go goes out with this one
            check_settings();
            check_config();
            check_launch();
            check_done();
        end
        check_ext_session();
    endtask

    initial begin
        string line;
        int fd;
        int v [NUM_COLS];
        void'($urandom(11));
        rstN = 1'b0;
        advance = 1'b0;
        next_addr = 1'b0;
        ext_toggle = 1'b0;
        sw = '0;
        m_done = '0;
        num_tests = 0;
        fd = $fopen("bus_ctrl_tests.txt", "r");
        if (fd == 0) stop_run("cannot open bus_ctrl_tests.txt");
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                            v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18],
                            v[19]) == NUM_COLS) begin
                    for (int c = 0; c < NUM_COLS; c++) begin
                        tests[num_tests][c] = v[c];
                    end
                    num_tests++;
                end
            end
        end
        $fclose(fd);
        if (num_tests == 0) stop_run("no scenarios found in bus_ctrl_tests.txt");
        fork
            begin
                #(num_tests * CYCLES_PER_TEST * 100);
                stop_run("timed out: the scenarios did not finish in time");
            end
        join_none
        for (cur = 0; cur < num_tests; cur++) begin
            run_scenario();
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: bus_ctrl_tests.txt
# sid0 sid1 rw in_ex first0 first1 len0 len1 last0 last1 n0 n1, then four bank words per master
# all hex, words past n are padding, last is first+len held at the slave depth
1 2 1 3 010 200 020 040 030 240 3 1 a101 a102 a103 0000 b201 0000 0000 0000
3 1 2 1 7f0 100 020 0ff 800 1ff 2 0 1111 2222 0000 0000 0000 0000 0000 0000
2 3 0 2 000 700 abc 100 abc 800 0 4 0000 0000 0000 0000 c001 c002 c003 c004
0 0 0 0 000 000 000 000 000 000 0 0 0000 0000 0000 0000 0000 0000 0000 0000
3 0 3 0 123 050 045 010 168 060 0 0 0000 0000 0000 0000 0000 0000 0000 0000
1 3 3 3 fff 3ff 000 7ff fff 800 4 2 d001 d002 d003 d004 e001 e002 0000 0000

// File: bus_ctrl_top.f
bus_ctrl_pkg.sv
write_bank.sv
config_sequencer.sv
com_launcher.sv
menu_fsm.sv
bus_ctrl_top.sv
bus_ctrl_tb.sv

// File: bus_ctrl_top.sv
`timescale 1ns/1ns

module bus_ctrl_top (
    input  logic clk,
    input  logic rstN,
    input  logic advance,
    input  logic next_addr,
    input  logic ext_toggle,
    input  logic [bus_ctrl_pkg::DATA_WIDTH-1:0] sw,
    input  logic [bus_ctrl_pkg::M_COUNT-1:0] m_done,
    output logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::SID_WIDTH-1:0] m_slave_id,
    output logic [bus_ctrl_pkg::M_COUNT-1:0] m_rd_wr,
    output logic [bus_ctrl_pkg::M_COUNT-1:0] m_in_ex,
    output logic [bus_ctrl_pkg::M_COUNT-1:0] m_burst,
    output logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::ADDR_WIDTH-1:0] m_address,
    output logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::DATA_WIDTH-1:0] m_data,
    output logic [bus_ctrl_pkg::M_COUNT:0] m_start,
    output logic [bus_ctrl_pkg::M_COUNT:0] m_eoc,
    output logic [3:0] status_led
);

    logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::ADDR_WIDTH-1:0] first_addr;
    logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::ADDR_WIDTH-1:0] last_addr;
    logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::ADDR_WIDTH-1:0] cfg_address;
    logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::BANK_AW-1:0] wr_count;
    logic [bus_ctrl_pkg::M_COUNT-1:0] cfg_start;
    logic [bus_ctrl_pkg::M_COUNT-1:0] int_eoc;
    logic [bus_ctrl_pkg::M_COUNT:0] com_start;
    logic [bus_ctrl_pkg::MID_WIDTH-1:0] bank_sel;
    logic [bus_ctrl_pkg::MID_WIDTH-1:0] rd_master;
    logic [bus_ctrl_pkg::BANK_AW-1:0] rd_ptr;
    logic [bus_ctrl_pkg::DATA_WIDTH-1:0] rd_data;
    logic bank_wr;
    logic bank_next;
    logic bank_clear;
    logic cfg_go;
    logic cfg_finished;
    logic launch;
    logic ext_allowed;
    logic addr_follow;
    logic ext_eoc;

    // config pulses and communication pulses never overlap in time
    assign m_start = com_start | {1'b0, cfg_start};
    assign m_eoc = {ext_eoc, int_eoc};

    always_comb begin
        for (int i = 0; i < bus_ctrl_pkg::M_COUNT; i++) begin
            m_address[i] = addr_follow ? sw[bus_ctrl_pkg::ADDR_WIDTH-1:0] : cfg_address[i];
        end
    end

    menu_fsm menu0 (
        .clk, .rstN, .advance, .next_addr, .sw, .m_done, .cfg_finished, .wr_count,
        .m_slave_id, .m_rd_wr, .m_in_ex, .m_burst, .first_addr, .last_addr, .int_eoc,
        .bank_wr, .bank_sel, .bank_clear, .bank_next, .cfg_go, .launch,
        .ext_allowed, .addr_follow, .status_led
    );

    write_bank bank0 (
        .clk, .rstN, .sw, .bank_wr, .bank_sel, .bank_next, .bank_clear,
        .rd_master, .rd_ptr, .rd_data, .wr_count
    );

    config_sequencer cfg0 (
        .clk, .rstN, .cfg_go, .m_in_ex, .wr_count, .first_addr, .last_addr, .rd_data,
        .rd_master, .rd_ptr, .cfg_start, .cfg_address,
        .cfg_data(m_data),
        .cfg_finished
    );

    com_launcher launch0 (
        .clk, .rstN, .launch, .ext_allowed, .ext_toggle, .com_start,
        .m_eoc(ext_eoc)
    );

endmodule

// File: com_launcher.sv
`timescale 1ns/1ns

module com_launcher (
    input  logic clk,
    input  logic rstN,
    input  logic launch,
    input  logic ext_allowed,
    input  logic ext_toggle,
    output logic [bus_ctrl_pkg::M_COUNT:0] com_start,
    output logic m_eoc                  // end of the external session
);

    logic pending;                      // second master still waiting
    logic [$clog2(bus_ctrl_pkg::COM_START_DELAY+1)-1:0] delay_cnt;
    logic session;                      // external session open

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            com_start <= '0;
            m_eoc <= 1'b0;
            pending <= 1'b0;
            delay_cnt <= '0;
            session <= 1'b0;
        end else begin
            com_start <= '0;
            m_eoc <= 1'b0;
            if (launch) begin
                com_start[bus_ctrl_pkg::FIRST_START_MASTER] <= 1'b1;
                pending <= 1'b1;
                delay_cnt <= '0;
            end else if (pending) begin
                delay_cnt <= delay_cnt + 1'b1;
                if (delay_cnt == bus_ctrl_pkg::COM_START_DELAY) begin
                    com_start[1 - bus_ctrl_pkg::FIRST_START_MASTER] <= 1'b1;
                    pending <= 1'b0;
                end
            end
            // open or close the external channel
            if (ext_allowed && ext_toggle) begin
                session <= !session;
                if (session) begin
                    m_eoc <= 1'b1;
                end else begin
                    com_start[bus_ctrl_pkg::M_COUNT] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: config_sequencer.sv
`timescale 1ns/1ns

module config_sequencer (
    input  logic clk,
    input  logic rstN,
    input  logic cfg_go,
    input  logic [bus_ctrl_pkg::M_COUNT-1:0] m_in_ex,
    input  logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::BANK_AW-1:0] wr_count,
    input  logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::ADDR_WIDTH-1:0] first_addr,
    input  logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::ADDR_WIDTH-1:0] last_addr,
    input  logic [bus_ctrl_pkg::DATA_WIDTH-1:0] rd_data,
    output logic [bus_ctrl_pkg::MID_WIDTH-1:0] rd_master,  // master of the next step
    output logic [bus_ctrl_pkg::BANK_AW-1:0] rd_ptr,       // bank word of the next step
    output logic [bus_ctrl_pkg::M_COUNT-1:0] cfg_start,
    output logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::ADDR_WIDTH-1:0] cfg_address,
    output logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::DATA_WIDTH-1:0] cfg_data,
    output logic cfg_finished
);

    bus_ctrl_pkg::config_state_t state, nxt_state;
    logic [bus_ctrl_pkg::MID_WIDTH-1:0] master;
    logic [bus_ctrl_pkg::BANK_AW-1:0] ptr;
    logic [$clog2(bus_ctrl_pkg::CONFIG_CLK_COUNT)-1:0] clk_cnt;
    logic last_cnt;
    logic load;      // latch word and address for rd_master
    logic pulse;     // start pulse on sub-state entry
    logic to_last;
    logic finish;

    assign last_cnt = (clk_cnt == bus_ctrl_pkg::CONFIG_CLK_COUNT - 1);

    always_comb begin
        nxt_state = state;
        rd_master = master;
        rd_ptr = ptr;
        load = 1'b0;
        pulse = 1'b0;
        to_last = 1'b0;
        finish = 1'b0;
        case (state)
            bus_ctrl_pkg::cfg_done: begin
                if (cfg_go) begin
                    nxt_state = bus_ctrl_pkg::cfg_start;
                    rd_master = '0;
                    rd_ptr = '0;
                    load = 1'b1;
                    pulse = 1'b1;
                end
            end
            bus_ctrl_pkg::cfg_start: begin
                if (last_cnt) begin
                    load = 1'b1;
                    to_last = 1'b1;
                    if (!m_in_ex[master] || wr_count[master] <= 1) begin  // nothing in between
                        nxt_state = bus_ctrl_pkg::cfg_last;
                        rd_ptr = wr_count[master];
                        pulse = 1'b1;
                    end else begin
                        nxt_state = bus_ctrl_pkg::cfg_middle;
                        rd_ptr = ptr + 1'b1;
                    end
                end
            end
            bus_ctrl_pkg::cfg_middle: begin
                if (last_cnt) begin
                    load = 1'b1;
                    to_last = 1'b1;
                    rd_ptr = ptr + 1'b1;
                    if (rd_ptr == wr_count[master]) begin  // final word goes with the last address
                        nxt_state = bus_ctrl_pkg::cfg_last;
                        pulse = 1'b1;
                    end
                end
            end
            bus_ctrl_pkg::cfg_last: begin
                if (last_cnt) begin
                    if (master == bus_ctrl_pkg::M_COUNT - 1) begin
                        nxt_state = bus_ctrl_pkg::cfg_done;
                        finish = 1'b1;
                    end else begin
                        nxt_state = bus_ctrl_pkg::cfg_start;
                        rd_master = master + 1'b1;
                        rd_ptr = '0;
                        load = 1'b1;
                        pulse = 1'b1;
                    end
                end
            end
            default: nxt_state = bus_ctrl_pkg::cfg_done;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= bus_ctrl_pkg::cfg_done;
            master <= '0;
            ptr <= '0;
            clk_cnt <= '0;
            cfg_start <= '0;
            cfg_finished <= 1'b0;
        end else begin
            state <= nxt_state;
            master <= rd_master;
            ptr <= rd_ptr;
            // every sub-state leaves on last_cnt, so the count restarts there
            clk_cnt <= (last_cnt || state == bus_ctrl_pkg::cfg_done) ? '0 : clk_cnt + 1'b1;
            cfg_start <= '0;
            if (pulse) cfg_start[rd_master] <= 1'b1;
            cfg_finished <= finish;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cfg_data[rd_master] <= rd_data;
            cfg_address[rd_master] <= to_last ? last_addr[rd_master] : first_addr[rd_master];
        end
    end

    // a new run is only requested while idle
    assert property (@(posedge clk) disable iff (!rstN)
        cfg_go |-> state == bus_ctrl_pkg::cfg_done);

endmodule

// File: menu_fsm.sv
`timescale 1ns/1ns

module menu_fsm (
    input  logic clk,
    input  logic rstN,
    input  logic advance,
    input  logic next_addr,
    input  logic [bus_ctrl_pkg::DATA_WIDTH-1:0] sw,
    input  logic [bus_ctrl_pkg::M_COUNT-1:0] m_done,
    input  logic cfg_finished,
    input  logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::BANK_AW-1:0] wr_count,
    output logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::SID_WIDTH-1:0] m_slave_id,
    output logic [bus_ctrl_pkg::M_COUNT-1:0] m_rd_wr,
    output logic [bus_ctrl_pkg::M_COUNT-1:0] m_in_ex,
    output logic [bus_ctrl_pkg::M_COUNT-1:0] m_burst,
    output logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::ADDR_WIDTH-1:0] first_addr,
    output logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::ADDR_WIDTH-1:0] last_addr,
    output logic [bus_ctrl_pkg::M_COUNT-1:0] int_eoc,
    output logic bank_wr,
    output logic [bus_ctrl_pkg::MID_WIDTH-1:0] bank_sel,
    output logic bank_clear,
    output logic bank_next,
    output logic cfg_go,
    output logic launch,
    output logic ext_allowed,
    output logic addr_follow,
    output logic [3:0] status_led
);

    bus_ctrl_pkg::main_state_t state, nxt_state;
    logic [bus_ctrl_pkg::ADDR_WIDTH-1:0] sw_addr;
    logic all_done;

    assign sw_addr = sw[bus_ctrl_pkg::ADDR_WIDTH-1:0];

    // first + length, held at the slave depth once the sum reaches it
    function automatic logic [bus_ctrl_pkg::ADDR_WIDTH-1:0] clamp_last(
        input logic [bus_ctrl_pkg::SID_WIDTH-1:0] sid,
        input logic [bus_ctrl_pkg::ADDR_WIDTH-1:0] first,
        input logic [bus_ctrl_pkg::ADDR_WIDTH-1:0] len
    );
        int depth;
        logic [bus_ctrl_pkg::ADDR_WIDTH:0] sum;
        depth = (sid == '0) ? bus_ctrl_pkg::SLAVE_DEPTHS[0] : bus_ctrl_pkg::SLAVE_DEPTHS[sid - 1];
        sum = {1'b0, first} + {1'b0, len};  // one extra bit so the carry is kept
        return (sum >= depth) ? depth[bus_ctrl_pkg::ADDR_WIDTH-1:0] : sum[bus_ctrl_pkg::ADDR_WIDTH-1:0];
    endfunction

    always_comb begin
        nxt_state = state;
        case (state)
            bus_ctrl_pkg::slave_sel: begin
                if (advance) begin
                    nxt_state = (sw[bus_ctrl_pkg::M_COUNT*bus_ctrl_pkg::SID_WIDTH-1:0] == '0) ?
                                bus_ctrl_pkg::com_done : bus_ctrl_pkg::rw_sel;
                end
            end
            bus_ctrl_pkg::rw_sel: if (advance) nxt_state = bus_ctrl_pkg::ext_write_sel;
            bus_ctrl_pkg::ext_write_sel: begin
                if (advance) begin
                    case (sw[1:0])  // one bit per master wanting bank words
                        2'b00: nxt_state = bus_ctrl_pkg::first_addr_m0;
                        2'b01: nxt_state = bus_ctrl_pkg::ext_write_m0;
                        2'b10: nxt_state = bus_ctrl_pkg::ext_write_m1;
                        default: nxt_state = bus_ctrl_pkg::ext_write_m01;
                    endcase
                end
            end
            bus_ctrl_pkg::ext_write_m0: if (advance) nxt_state = bus_ctrl_pkg::first_addr_m0;
            bus_ctrl_pkg::ext_write_m01: if (advance) nxt_state = bus_ctrl_pkg::ext_write_m1;
            bus_ctrl_pkg::ext_write_m1: if (advance) nxt_state = bus_ctrl_pkg::first_addr_m0;
            bus_ctrl_pkg::first_addr_m0: if (advance) nxt_state = bus_ctrl_pkg::first_addr_m1;
            bus_ctrl_pkg::first_addr_m1: if (advance) nxt_state = bus_ctrl_pkg::len_m0;
            bus_ctrl_pkg::len_m0: if (advance) nxt_state = bus_ctrl_pkg::len_m1;
            bus_ctrl_pkg::len_m1: if (advance) nxt_state = bus_ctrl_pkg::config_masters;
            bus_ctrl_pkg::config_masters: if (cfg_finished) nxt_state = bus_ctrl_pkg::com_ready;
            bus_ctrl_pkg::com_ready: if (advance) nxt_state = bus_ctrl_pkg::communicating;
            bus_ctrl_pkg::communicating: if (all_done) nxt_state = bus_ctrl_pkg::com_done;
            default: nxt_state = state;  // com_done holds until reset
        endcase
    end

    // a master with no slave counts as done
    always_comb begin
        all_done = 1'b1;
        for (int i = 0; i < bus_ctrl_pkg::M_COUNT; i++) begin
            all_done = all_done && (m_done[i] || (m_slave_id[i] == '0));
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= bus_ctrl_pkg::slave_sel;
            m_slave_id <= '0;
            m_rd_wr <= '0;
            m_in_ex <= '0;
            m_burst <= '0;
            first_addr <= '0;
            last_addr <= '0;
            int_eoc <= '0;
        end else begin
            state <= nxt_state;
            int_eoc <= '0;
            case (state)
                bus_ctrl_pkg::slave_sel: begin
                    m_slave_id <= sw[bus_ctrl_pkg::M_COUNT*bus_ctrl_pkg::SID_WIDTH-1:0];
                    if (nxt_state == bus_ctrl_pkg::com_done) int_eoc <= '1;  // masters skip to their end
                end
                bus_ctrl_pkg::rw_sel: m_rd_wr <= sw[bus_ctrl_pkg::M_COUNT-1:0];
                bus_ctrl_pkg::ext_write_sel: m_in_ex <= sw[bus_ctrl_pkg::M_COUNT-1:0];
                bus_ctrl_pkg::first_addr_m0: first_addr[0] <= sw_addr;
                bus_ctrl_pkg::first_addr_m1: first_addr[1] <= sw_addr;
                bus_ctrl_pkg::len_m0: last_addr[0] <= clamp_last(m_slave_id[0], first_addr[0], sw_addr);
                bus_ctrl_pkg::len_m1: last_addr[1] <= clamp_last(m_slave_id[1], first_addr[1], sw_addr);
                default: ;
            endcase
            if (bank_next) m_burst[bank_sel] <= 1'b1;  // more than one word entered
        end
    end

    assign bank_wr = state inside {bus_ctrl_pkg::ext_write_m0, bus_ctrl_pkg::ext_write_m01,
                                   bus_ctrl_pkg::ext_write_m1};
    assign bank_sel = (state == bus_ctrl_pkg::ext_write_m1);
    // a full bank ignores further next_addr strobes
    assign bank_next = bank_wr && next_addr && (wr_count[bank_sel] != bus_ctrl_pkg::BANK_DEPTH - 1);
    assign bank_clear = bank_wr && advance;
    assign cfg_go = (state == bus_ctrl_pkg::len_m1) && advance;
    assign launch = (state == bus_ctrl_pkg::com_ready) && advance;
    assign ext_allowed = state inside {bus_ctrl_pkg::communicating, bus_ctrl_pkg::com_done};
    assign addr_follow = (state == bus_ctrl_pkg::com_done);
    assign status_led = {state == bus_ctrl_pkg::communicating, state == bus_ctrl_pkg::com_done,
                         state == bus_ctrl_pkg::com_ready, state == bus_ctrl_pkg::slave_sel};

    // the sequencer reports back only while the menu waits for it
    assert property (@(posedge clk) disable iff (!rstN)
        cfg_finished |-> state == bus_ctrl_pkg::config_masters);

endmodule

// File: write_bank.sv
`timescale 1ns/1ns

module write_bank (
    input  logic clk,
    input  logic rstN,
    input  logic [bus_ctrl_pkg::DATA_WIDTH-1:0] sw,
    input  logic bank_wr,
    input  logic [bus_ctrl_pkg::MID_WIDTH-1:0] bank_sel,
    input  logic bank_next,
    input  logic bank_clear,
    input  logic [bus_ctrl_pkg::MID_WIDTH-1:0] rd_master,
    input  logic [bus_ctrl_pkg::BANK_AW-1:0] rd_ptr,
    output logic [bus_ctrl_pkg::DATA_WIDTH-1:0] rd_data,
    output logic [bus_ctrl_pkg::M_COUNT-1:0][bus_ctrl_pkg::BANK_AW-1:0] wr_count
);

    logic [bus_ctrl_pkg::DATA_WIDTH-1:0] mem [bus_ctrl_pkg::M_COUNT][bus_ctrl_pkg::BANK_DEPTH];
    logic [bus_ctrl_pkg::BANK_AW-1:0] wr_ptr;  // shared by both masters

    // the word under the pointer tracks the switches
    always_ff @(posedge clk) begin
        if (bank_wr) mem[bank_sel][wr_ptr] <= sw;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wr_ptr <= '0;
            wr_count <= '0;
        end else if (bank_clear) begin
            wr_ptr <= '0;  // next master starts at word 0
        end else if (bank_next) begin
            wr_ptr <= wr_ptr + 1'b1;
            wr_count[bank_sel] <= wr_count[bank_sel] + 1'b1;
        end
    end

    assign rd_data = mem[rd_master][rd_ptr];

    // menu gating has to stop the count before it wraps
    assert property (@(posedge clk) disable iff (!rstN)
        bank_next |-> wr_count[bank_sel] < bus_ctrl_pkg::BANK_DEPTH - 1);

endmodule
